//--- list.f
rtl/loader_pkg.sv
rtl/cbm2_map_pkg.sv
rtl/mem_wr_if.sv
rtl/rom_loader.sv
rtl/ram_eraser.sv
rtl/basic_ptr_injector.sv
rtl/mem_write_arbiter.sv
rtl/cbm2_loader_top.sv
sim/tb_loader.sv

//--- rtl/basic_ptr_injector.sv
/*
 * BASIC pointer injector
 * After a PRG load, sets TXTTAB, TXTEND, TXTPTR and BUFFPT in the system
 * page the way a LOAD command leaves them
 */

`timescale 1ns/10ps

module basic_ptr_injector (
	input  logic               clk_sys,
	input  logic               arst_n_i,
	input  logic               prg_done_i,
	input  logic [15:0]        prg_start_i,
	input  logic [15:0]        prg_end_i,
	input  loader_pkg::model_e model_i,
	mem_wr_if.source           wr,
	output logic               freeze_o
);

	typedef enum logic {
		INJ_IDLE,
		INJ_WRITE
	} inj_state_e;

	inj_state_e            state_q;
	logic [3:0]            step_q;
	logic [15:0]           start_q;
	logic [15:0]           end_q;
	logic                  bank_q;
	logic [7:0]            ofs;
	loader_pkg::mem_data_t ptr_byte;

	// Pointer bytes in ascending offset order
	always_comb begin
		case (step_q)
			4'd0: {ofs, ptr_byte} = {cbm2_map_pkg::TXTTAB_LO, start_q[7:0]};
			4'd1: {ofs, ptr_byte} = {cbm2_map_pkg::TXTTAB_HI, start_q[15:8]};
			4'd2: {ofs, ptr_byte} = {cbm2_map_pkg::TXTEND_LO, end_q[7:0]};
			4'd3: {ofs, ptr_byte} = {cbm2_map_pkg::TXTEND_HI, end_q[15:8]};
			4'd4: {ofs, ptr_byte} = {cbm2_map_pkg::TXTPTR_LO, end_q[7:0]};
			4'd5: {ofs, ptr_byte} = {cbm2_map_pkg::TXTPTR_HI, end_q[15:8]};
			4'd6: {ofs, ptr_byte} = {cbm2_map_pkg::TXTPTR_BANK, 7'd0, bank_q};
			4'd7: {ofs, ptr_byte} = {cbm2_map_pkg::BUFFPT_LO, start_q[7:0]};
			4'd8: {ofs, ptr_byte} = {cbm2_map_pkg::BUFFPT_HI, start_q[15:8]};
			default: {ofs, ptr_byte} = {cbm2_map_pkg::BUFFPT_BANK, 7'd0, bank_q};
		endcase
	end

	assign wr.valid = state_q == INJ_WRITE;
	assign wr.addr  = cbm2_map_pkg::SEG15_BASE + loader_pkg::mem_addr_t'(ofs);
	assign wr.data  = ptr_byte;
	assign freeze_o = state_q == INJ_WRITE;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= INJ_IDLE;
			step_q  <= 4'd0;
		end else if (state_q == INJ_IDLE) begin
			if (prg_done_i) begin
				state_q <= INJ_WRITE;
				step_q  <= 4'd0;
			end
		end else if (wr.valid && wr.ready) begin
			// Ten bytes, last one is the BUFFPT bank
			if (step_q == 4'd9)
				state_q <= INJ_IDLE;
			else
				step_q <= step_q + 1'b1;
		end
	end

	// Snapshot of the load result
	always_ff @(posedge clk_sys) begin
		if (prg_done_i && state_q == INJ_IDLE) begin
			start_q <= prg_start_i;
			end_q   <= prg_end_i;
			bank_q  <= model_i == loader_pkg::MODEL_B;
		end
	end

endmodule

//--- rtl/cbm2_loader_top.sv
/*
 * CBM-II memory loading engine
 * ROM and PRG download, BASIC pointer injection and RAM erase sharing
 * one byte-wide memory write port
 */

`timescale 1ns/10ps

module cbm2_loader_top (
	input  logic                    clk_sys,
	input  logic                    arst_n_i,
	input  logic                    dl_active_i,
	input  logic                    dl_valid_i,
	output logic                    dl_ready_o,
	input  loader_pkg::dl_index_e   dl_index_i,
	input  loader_pkg::mem_addr_t   dl_offset_i,
	input  loader_pkg::mem_data_t   dl_data_i,
	input  logic                    erase_req_i,
	input  loader_pkg::erase_mode_e erase_mode_i,
	input  logic                    erase_cancel_i,
	input  loader_pkg::model_e      model_i,
	input  loader_pkg::ram_size_e   ram_size_i,
	input  logic                    prg_use_header_i,
	output logic                    mem_valid_o,
	input  logic                    mem_ready_i,
	output loader_pkg::mem_addr_t   mem_addr_o,
	output loader_pkg::mem_data_t   mem_data_o,
	output logic                    erasing_o,
	output logic                    freeze_o,
	output logic [2:0]              ext_rom_o,
	output logic                    chrgen_wr_o,
	output logic [13:0]             chrgen_addr_o,
	output loader_pkg::mem_data_t   chrgen_data_o
);

	mem_wr_if load_wr ();
	mem_wr_if erase_wr ();
	mem_wr_if inject_wr ();

	logic [15:0] prg_start;
	logic [15:0] prg_end;
	logic        prg_done;
	logic        inj_freeze;

	// CPU held during the PRG load, the hand-over cycle and the injection
	assign freeze_o = (dl_active_i && dl_index_i == loader_pkg::IDX_PRG) || prg_done
		|| inj_freeze;

	rom_loader u_loader (
		.clk_sys, .arst_n_i, .dl_active_i, .dl_valid_i, .dl_ready_o,
		.dl_index_i, .dl_offset_i, .dl_data_i, .model_i, .prg_use_header_i,
		.wr (load_wr),
		.ext_rom_o, .chrgen_wr_o, .chrgen_addr_o, .chrgen_data_o,
		.prg_start_o (prg_start),
		.prg_end_o   (prg_end),
		.prg_done_o  (prg_done)
	);

	ram_eraser u_eraser (
		.clk_sys, .arst_n_i, .erase_req_i, .erase_mode_i, .erase_cancel_i,
		.model_i, .ram_size_i,
		.wr (erase_wr),
		.erasing_o
	);

	basic_ptr_injector u_injector (
		.clk_sys, .arst_n_i,
		.prg_done_i  (prg_done),
		.prg_start_i (prg_start),
		.prg_end_i   (prg_end),
		.model_i,
		.wr          (inject_wr),
		.freeze_o    (inj_freeze)
	);

	mem_write_arbiter u_arbiter (
		.clk_sys, .arst_n_i,
		.erase_src  (erase_wr),
		.inject_src (inject_wr),
		.load_src   (load_wr),
		.mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_data_o
	);

endmodule

//--- rtl/cbm2_map_pkg.sv
/*
 * CBM-II memory map
 * SDRAM placement of the system and external ROMs, RAM bank bases,
 * erase regions and the BASIC pointer locations in the system page
 */

package cbm2_map_pkg;

	// ==========================================================================
	// ROM targets
	// ==========================================================================
	localparam loader_pkg::mem_addr_t ROM_B6X0_BASE = 25'h100_0000;
	localparam loader_pkg::mem_addr_t ROM_B7X0_BASE = 25'h101_0000;
	localparam loader_pkg::mem_addr_t ROM_P500_BASE = 25'h102_0000;
	localparam loader_pkg::mem_addr_t EXT_ROM_BASE0 = 25'h103_2000;
	localparam loader_pkg::mem_addr_t EXT_ROM_BASE1 = 25'h103_4000;
	localparam loader_pkg::mem_addr_t EXT_ROM_BASE2 = 25'h103_6000;

	localparam logic [16:0] SYS_ROM_LEN = 17'hB000;
	localparam logic [16:0] EXT_ROM_LEN = 17'h2000;

	// Character generator lives in the $Axxx block of B series ROMs
	localparam logic [3:0] CHRGEN_NIBBLE = 4'hA;

	// ==========================================================================
	// RAM and erase regions
	// ==========================================================================
	localparam loader_pkg::mem_addr_t SEG15_BASE    = 25'h0F_0000;
	localparam loader_pkg::mem_addr_t SEG15_LOW_END = 25'h0F_0FFF;
	localparam loader_pkg::mem_addr_t VIDRAM_BASE   = 25'h0F_D000;
	localparam loader_pkg::mem_addr_t ERASE_LAST    = 25'h0F_D7FF;

	localparam loader_pkg::mem_addr_t RAM_BASE_P = 25'h00_0000;
	localparam loader_pkg::mem_addr_t RAM_BASE_B = 25'h01_0000;

	// Indexed by {ram size bit 0, model}
	localparam loader_pkg::mem_addr_t RAM_END [4] = '{
		25'h01_FFFF,   // 128K P
		25'h02_FFFF,   // 128K B
		25'h03_FFFF,   // 256K P
		25'h04_FFFF    // 256K B
	};

	// ==========================================================================
	// BASIC pointers in the system page
	// ==========================================================================
	localparam logic [7:0] TXTTAB_LO   = 8'h2D;
	localparam logic [7:0] TXTTAB_HI   = 8'h2E;
	localparam logic [7:0] TXTEND_LO   = 8'h2F;
	localparam logic [7:0] TXTEND_HI   = 8'h30;
	localparam logic [7:0] TXTPTR_LO   = 8'h96;
	localparam logic [7:0] TXTPTR_HI   = 8'h97;
	localparam logic [7:0] TXTPTR_BANK = 8'h98;
	localparam logic [7:0] BUFFPT_LO   = 8'h99;
	localparam logic [7:0] BUFFPT_HI   = 8'h9A;
	localparam logic [7:0] BUFFPT_BANK = 8'h9B;

	// Load address used when the PRG header is ignored
	localparam logic [15:0] PRG_DEFAULT_START = 16'h0003;

endpackage

//--- rtl/loader_pkg.sv
/*
 * Loader vocabulary
 * Download kinds, erase modes, machine model and RAM size, plus the
 * address and data types shared by every write channel
 */

package loader_pkg;

	// SDRAM byte address and byte data
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;

	// Download kinds as sent by the host
	typedef enum logic [7:0] {
		IDX_P500    = 8'd1,
		IDX_B6X0    = 8'd2,
		IDX_B7X0    = 8'd3,
		IDX_EXT2000 = 8'd4,
		IDX_EXT4000 = 8'd5,
		IDX_EXT6000 = 8'd6,
		IDX_PRG     = 8'd9
	} dl_index_e;

	typedef enum logic [1:0] {
		ERASE_NONE,
		ERASE_SEG15,
		ERASE_ALL
	} erase_mode_e;

	// Professional (P500) or Business (B series)
	typedef enum logic {
		MODEL_P,
		MODEL_B
	} model_e;

	typedef enum logic [1:0] {
		RAM_128K,
		RAM_256K,
		RAM_896K
	} ram_size_e;

endpackage

//--- rtl/mem_wr_if.sv
/*
 * Byte write channel
 * One address/data write request with a valid/ready handshake
 */

`timescale 1ns/10ps

interface mem_wr_if;

	logic                  valid;
	logic                  ready;
	loader_pkg::mem_addr_t addr;
	loader_pkg::mem_data_t data;

	// Write source side
	modport source (output valid, output addr, output data, input ready);

	// Arbiter side
	modport sink (input valid, input addr, input data, output ready);

endinterface

//--- rtl/mem_write_arbiter.sv
/*
 * Memory write arbiter
 * Fixed priority eraser, injector, loader into a one-entry output
 * register facing the memory port
 */

`timescale 1ns/10ps

module mem_write_arbiter (
	input  logic                   clk_sys,
	input  logic                   arst_n_i,
	mem_wr_if.sink                 erase_src,
	mem_wr_if.sink                 inject_src,
	mem_wr_if.sink                 load_src,
	output logic                   mem_valid_o,
	input  logic                   mem_ready_i,
	output loader_pkg::mem_addr_t  mem_addr_o,
	output loader_pkg::mem_data_t  mem_data_o
);

	loader_pkg::mem_addr_t sel_addr;
	loader_pkg::mem_data_t sel_data;
	logic                  slot_free;
	logic                  take;

	// Register empty or emptying this cycle
	assign slot_free = !mem_valid_o || mem_ready_i;

	assign erase_src.ready  = slot_free;
	assign inject_src.ready = slot_free && !erase_src.valid;
	assign load_src.ready   = slot_free && !erase_src.valid && !inject_src.valid;

	assign take = slot_free && (erase_src.valid || inject_src.valid || load_src.valid);

	always_comb begin
		if (erase_src.valid) begin
			sel_addr = erase_src.addr;
			sel_data = erase_src.data;
		end else if (inject_src.valid) begin
			sel_addr = inject_src.addr;
			sel_data = inject_src.data;
		end else begin
			sel_addr = load_src.addr;
			sel_data = load_src.data;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i)
			mem_valid_o <= 1'b0;
		else if (take)
			mem_valid_o <= 1'b1;
		else if (mem_ready_i)
			mem_valid_o <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			mem_addr_o <= sel_addr;
			mem_data_o <= sel_data;
		end
	end

	// A waiting write must not move
	a_mem_hold: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o)
			&& $stable(mem_data_o))
		else $error("mem_write_arbiter: write changed while stalled");

endmodule

//--- rtl/ram_eraser.sv
/*
 * RAM eraser
 * Fills RAM with the power-on pattern, either all banks plus segment 15
 * or only the low part of segment 15 and the video RAM
 */

`timescale 1ns/10ps

module ram_eraser (
	input  logic                    clk_sys,
	input  logic                    arst_n_i,
	input  logic                    erase_req_i,
	input  loader_pkg::erase_mode_e erase_mode_i,
	input  logic                    erase_cancel_i,
	input  loader_pkg::model_e      model_i,
	input  loader_pkg::ram_size_e   ram_size_i,
	mem_wr_if.source                wr,
	output logic                    erasing_o
);

	typedef enum logic [1:0] {
		IDLE,
		RAM,
		SEG15_LOW,
		VIDRAM
	} erase_state_e;

	erase_state_e          state_q;
	loader_pkg::mem_addr_t addr_q;
	logic                  wr_fire;
	logic                  ram_wrap;
	logic                  pat_bit;

	assign wr_fire  = wr.valid && wr.ready;
	// 896K fills everything below segment 15, so no jump there
	assign ram_wrap = ram_size_i != loader_pkg::RAM_896K
		&& addr_q == cbm2_map_pkg::RAM_END[{ram_size_i[0], model_i}];
	assign pat_bit  = addr_q[14] ^ addr_q[3] ^ addr_q[2];

	assign wr.valid  = state_q != IDLE;
	assign wr.addr   = addr_q;
	assign wr.data   = {8{pat_bit}};
	assign erasing_o = state_q != IDLE;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			addr_q  <= '0;
		end else if (erase_cancel_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (erase_req_i && erase_mode_i == loader_pkg::ERASE_ALL) begin
						state_q <= RAM;
						addr_q  <= (model_i == loader_pkg::MODEL_B) ? cbm2_map_pkg::RAM_BASE_B
							: cbm2_map_pkg::RAM_BASE_P;
					end else if (erase_req_i && erase_mode_i == loader_pkg::ERASE_SEG15) begin
						state_q <= SEG15_LOW;
						addr_q  <= cbm2_map_pkg::SEG15_BASE;
					end
				end
				// Bank RAM, then all of segment 15 up to the end of video RAM
				RAM: begin
					if (wr_fire) begin
						if (addr_q == cbm2_map_pkg::ERASE_LAST)
							state_q <= IDLE;
						else if (ram_wrap)
							addr_q <= cbm2_map_pkg::SEG15_BASE;
						else
							addr_q <= addr_q + 1'b1;
					end
				end
				SEG15_LOW: begin
					if (wr_fire) begin
						if (addr_q == cbm2_map_pkg::SEG15_LOW_END) begin
							state_q <= VIDRAM;
							addr_q  <= cbm2_map_pkg::VIDRAM_BASE;
						end else begin
							addr_q <= addr_q + 1'b1;
						end
					end
				end
				VIDRAM: begin
					if (wr_fire) begin
						if (addr_q == cbm2_map_pkg::ERASE_LAST)
							state_q <= IDLE;
						else
							addr_q <= addr_q + 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

endmodule

//--- rtl/rom_loader.sv
/*
 * ROM and PRG loader
 * Turns the download stream into memory writes at the fixed ROM targets,
 * flags loaded external ROMs, feeds the character generator and parses
 * the PRG load address
 */

`timescale 1ns/10ps

module rom_loader (
	input  logic                  clk_sys,
	input  logic                  arst_n_i,
	input  logic                  dl_active_i,
	input  logic                  dl_valid_i,
	output logic                  dl_ready_o,
	input  loader_pkg::dl_index_e dl_index_i,
	input  loader_pkg::mem_addr_t dl_offset_i,
	input  loader_pkg::mem_data_t dl_data_i,
	input  loader_pkg::model_e    model_i,
	input  logic                  prg_use_header_i,
	mem_wr_if.source              wr,
	output logic [2:0]            ext_rom_o,
	output logic                  chrgen_wr_o,
	output logic [13:0]           chrgen_addr_o,
	output loader_pkg::mem_data_t chrgen_data_o,
	output logic [15:0]           prg_start_o,
	output logic [15:0]           prg_end_o,
	output logic                  prg_done_o
);

	loader_pkg::mem_addr_t rom_base;
	loader_pkg::mem_addr_t cur_addr;
	loader_pkg::mem_addr_t next_addr_q;
	loader_pkg::mem_data_t hdr_byte;
	logic [16:0]           rom_len;
	logic [2:0]            ext_sel;
	logic                  is_prg;
	logic                  is_chr;
	logic                  header;
	logic                  in_range;
	logic                  dl_fire;
	logic                  wr_fire;
	logic                  prg_active_q;

	// Target selection per file kind
	always_comb begin
		rom_base = '0;
		rom_len  = '0;
		ext_sel  = 3'b000;
		case (dl_index_i)
			loader_pkg::IDX_P500: begin
				rom_base = cbm2_map_pkg::ROM_P500_BASE;
				rom_len  = cbm2_map_pkg::SYS_ROM_LEN;
			end
			loader_pkg::IDX_B6X0: begin
				rom_base = cbm2_map_pkg::ROM_B6X0_BASE;
				rom_len  = cbm2_map_pkg::SYS_ROM_LEN;
			end
			loader_pkg::IDX_B7X0: begin
				rom_base = cbm2_map_pkg::ROM_B7X0_BASE;
				rom_len  = cbm2_map_pkg::SYS_ROM_LEN;
			end
			loader_pkg::IDX_EXT2000: begin
				rom_base = cbm2_map_pkg::EXT_ROM_BASE0;
				rom_len  = cbm2_map_pkg::EXT_ROM_LEN;
				ext_sel  = 3'b001;
			end
			loader_pkg::IDX_EXT4000: begin
				rom_base = cbm2_map_pkg::EXT_ROM_BASE1;
				rom_len  = cbm2_map_pkg::EXT_ROM_LEN;
				ext_sel  = 3'b010;
			end
			loader_pkg::IDX_EXT6000: begin
				rom_base = cbm2_map_pkg::EXT_ROM_BASE2;
				rom_len  = cbm2_map_pkg::EXT_ROM_LEN;
				ext_sel  = 3'b100;
			end
			// PRG data goes to bank 1 on B models
			loader_pkg::IDX_PRG: rom_base = {8'd0, model_i == loader_pkg::MODEL_B, prg_start_o};
			default: ;
		endcase
	end

	assign is_prg   = dl_index_i == loader_pkg::IDX_PRG;
	assign header   = is_prg && dl_offset_i < 25'd2;
	assign in_range = is_prg ? !header : dl_offset_i < {8'd0, rom_len};
	assign is_chr   = (dl_index_i == loader_pkg::IDX_B6X0 || dl_index_i == loader_pkg::IDX_B7X0)
		&& dl_offset_i[15:12] == cbm2_map_pkg::CHRGEN_NIBBLE;

	// First data byte takes the base, later bytes follow on
	assign cur_addr = (dl_offset_i == (is_prg ? 25'd2 : 25'd0)) ? rom_base : next_addr_q;

	assign wr.valid   = dl_active_i && dl_valid_i && in_range;
	assign wr.addr    = cur_addr;
	assign wr.data    = dl_data_i;
	// Header and dropped bytes are swallowed without a write
	assign dl_ready_o = dl_active_i && (in_range ? wr.ready : 1'b1);
	assign dl_fire    = dl_valid_i && dl_ready_o;
	assign wr_fire    = wr.valid && wr.ready;
	assign prg_done_o = prg_active_q && !dl_active_i;

	assign hdr_byte = prg_use_header_i ? dl_data_i
		: (dl_offset_i[0] ? cbm2_map_pkg::PRG_DEFAULT_START[15:8]
			: cbm2_map_pkg::PRG_DEFAULT_START[7:0]);

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ext_rom_o    <= 3'b000;
			chrgen_wr_o  <= 1'b0;
			prg_active_q <= 1'b0;
		end else begin
			chrgen_wr_o <= wr_fire && is_chr;
			if (dl_fire)
				ext_rom_o <= ext_rom_o | ext_sel;
			if (dl_active_i && is_prg)
				prg_active_q <= 1'b1;
			else if (!dl_active_i)
				prg_active_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_fire) begin
			next_addr_q   <= cur_addr + 1'b1;
			chrgen_addr_o <= {cur_addr[16], cur_addr[12:0]};
			chrgen_data_o <= dl_data_i;
		end
		// Start low byte at offset 0, high byte at offset 1
		if (dl_fire && header) begin
			if (dl_offset_i[0]) begin
				prg_start_o[15:8] <= hdr_byte;
				prg_end_o[15:8]   <= hdr_byte;
			end else begin
				prg_start_o[7:0] <= hdr_byte;
				prg_end_o[7:0]   <= hdr_byte;
			end
		end else if (wr_fire && is_prg) begin
			prg_end_o <= prg_end_o + 1'b1;
		end
	end

	// The running address never leaves the window that the offset filter allows
	a_rom_window: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		wr.valid && !is_prg |-> wr.addr >= rom_base && wr.addr - rom_base < {8'd0, rom_len})
		else $error("rom_loader: write to %h outside ROM window", wr.addr);

endmodule

//--- sim/tb_loader.sv
/*
 * Testbench for the CBM-II memory loading engine
 * Drives ROM, external ROM and PRG downloads and two erase runs against a
 * memory model with random ready, and checks the writes with assertions
 */

`timescale 1ns/10ps

module tb_loader;

	localparam int CLK_PERIOD  = 10;
	// Transfers of all tests at up to three cycles each
	localparam int TOTAL_XFERS = 'hB100 + 'h2000 + 17 + 'h1800 + 1000;
	localparam int WATCHDOG_NS = TOTAL_XFERS * 3 * CLK_PERIOD;

	logic                    clk_sys;
	logic                    arst_n_i;
	logic                    dl_active_i;
	logic                    dl_valid_i;
	logic                    dl_ready_o;
	loader_pkg::dl_index_e   dl_index_i;
	loader_pkg::mem_addr_t   dl_offset_i;
	loader_pkg::mem_data_t   dl_data_i;
	logic                    erase_req_i;
	loader_pkg::erase_mode_e erase_mode_i;
	logic                    erase_cancel_i;
	loader_pkg::model_e      model_i;
	loader_pkg::ram_size_e   ram_size_i;
	logic                    prg_use_header_i;
	logic                    mem_valid_o;
	logic                    mem_ready_i;
	loader_pkg::mem_addr_t   mem_addr_o;
	loader_pkg::mem_data_t   mem_data_o;
	logic                    erasing_o;
	logic                    freeze_o;
	logic [2:0]              ext_rom_o;
	logic                    chrgen_wr_o;
	logic [13:0]             chrgen_addr_o;
	loader_pkg::mem_data_t   chrgen_data_o;

	// Memory model and bookkeeping
	loader_pkg::mem_data_t mem [loader_pkg::mem_addr_t];
	loader_pkg::mem_data_t rom_img [0:'hB0FF];
	int                    wr_count;
	int                    chr_count;
	int                    cancel_count;
	logic                  chr_window;
	logic                  stall_q;
	loader_pkg::mem_addr_t hold_addr;
	loader_pkg::mem_data_t hold_data;
	logic [31:0]           ready_seed;
	logic [31:0]           data_seed;

	cbm2_loader_top u_dut (
		.clk_sys, .arst_n_i, .dl_active_i, .dl_valid_i, .dl_ready_o,
		.dl_index_i, .dl_offset_i, .dl_data_i,
		.erase_req_i, .erase_mode_i, .erase_cancel_i,
		.model_i, .ram_size_i, .prg_use_header_i,
		.mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_data_o,
		.erasing_o, .freeze_o, .ext_rom_o,
		.chrgen_wr_o, .chrgen_addr_o, .chrgen_data_o
	);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Power-on fill pattern
	function automatic loader_pkg::mem_data_t fill_byte(input loader_pkg::mem_addr_t a);
		return {8{a[14] ^ a[3] ^ a[2]}};
	endfunction

	task automatic value_error(input string sig, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("error at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic plain_error(input string what);
		$display("at %0t ns: %s", $time, what);
		$display("Test failures found");
		$fatal(1);
	endtask

	// ==========================================================================
	// Memory port with random ready, write capture and handshake checks
	// ==========================================================================
	always @(posedge clk_sys) begin
		#1;
		ready_seed = lcg_next(ready_seed);
		mem_ready_i = ready_seed[31:30] != 2'b00;
	end

	always @(posedge clk_sys) begin
		if (arst_n_i) begin
			// A stalled write keeps its address and data
			if (stall_q) begin
				assert (mem_valid_o) else value_error("mem_valid_o", 1, mem_valid_o);
				assert (mem_addr_o == hold_addr)
					else value_error("mem_addr_o", hold_addr, mem_addr_o);
				assert (mem_data_o == hold_data)
					else value_error("mem_data_o", hold_data, mem_data_o);
			end
			if (erasing_o)
				assert (!dl_ready_o) else value_error("dl_ready_o", 0, dl_ready_o);
			if (chrgen_wr_o) begin
				assert (chr_window)
					else plain_error("chrgen_wr_o pulsed outside the B6x0 ROM download");
				// Pulse n carries image byte 0xA000 + n at character address n
				assert (chrgen_addr_o == {2'b00, chr_count[11:0]})
					else value_error("chrgen_addr_o", {2'b00, chr_count[11:0]},
						chrgen_addr_o);
				assert (chrgen_data_o == rom_img['hA000 + chr_count])
					else value_error("chrgen_data_o", rom_img['hA000 + chr_count],
						chrgen_data_o);
				chr_count++;
			end
			if (mem_valid_o && mem_ready_i) begin
				mem[mem_addr_o] = mem_data_o;
				wr_count++;
			end
			stall_q   = mem_valid_o && !mem_ready_i;
			hold_addr = mem_addr_o;
			hold_data = mem_data_o;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		plain_error("timeout, the run did not finish within the expected time");
	end

	// ==========================================================================
	// Stimulus helpers
	// ==========================================================================
	task automatic send_byte(input loader_pkg::mem_addr_t ofs, input loader_pkg::mem_data_t b);
		dl_valid_i  = 1'b1;
		dl_offset_i = ofs;
		dl_data_i   = b;
		do
			@(posedge clk_sys);
		while (!dl_ready_o);
		#1;
		dl_valid_i = 1'b0;
	endtask

	// Waits until the output register is empty
	task automatic wait_mem_idle;
		do
			@(posedge clk_sys);
		while (mem_valid_o);
		#1;
	endtask

	task automatic clear_mem;
		mem.delete();
		wr_count  = 0;
		chr_count = 0;
	endtask

	task automatic send_rom(input loader_pkg::dl_index_e kind, input int len);
		dl_index_i  = kind;
		dl_active_i = 1'b1;
		for (int n = 0; n < len; n++)
			send_byte(loader_pkg::mem_addr_t'(n), rom_img[n]);
		dl_active_i = 1'b0;
		wait_mem_idle();
	endtask

	task automatic start_erase(input loader_pkg::erase_mode_e mode);
		erase_mode_i = mode;
		erase_req_i  = 1'b1;
		@(posedge clk_sys);
		#1;
		erase_req_i = 1'b0;
		assert (erasing_o) else value_error("erasing_o", 1, erasing_o);
	endtask

	task automatic check_mem(input loader_pkg::mem_addr_t a, input loader_pkg::mem_data_t exp_b);
		assert (mem.exists(a))
			else plain_error($sformatf("no write reached address %h", a));
		assert (mem[a] == exp_b) else value_error($sformatf("mem[%h]", a), exp_b, mem[a]);
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin
		arst_n_i         = 1'b0;
		dl_active_i      = 1'b0;
		dl_valid_i       = 1'b0;
		dl_index_i       = loader_pkg::IDX_B6X0;
		dl_offset_i      = '0;
		dl_data_i        = '0;
		erase_req_i      = 1'b0;
		erase_mode_i     = loader_pkg::ERASE_NONE;
		erase_cancel_i   = 1'b0;
		model_i          = loader_pkg::MODEL_P;
		ram_size_i       = loader_pkg::RAM_128K;
		prg_use_header_i = 1'b1;
		mem_ready_i      = 1'b0;
		ready_seed       = 32'd13384;
		data_seed        = lcg_next(32'd13384);
		chr_window       = 1'b0;
		stall_q          = 1'b0;
		clear_mem();
		for (int n = 0; n <= 'hB0FF; n++) begin
			data_seed  = lcg_next(data_seed);
			rom_img[n] = data_seed[23:16];
		end
		repeat (3) @(posedge clk_sys);
		#1;
		arst_n_i = 1'b1;
		assert ({mem_valid_o, dl_ready_o, erasing_o, freeze_o, chrgen_wr_o, ext_rom_o} == '0)
			else value_error("outputs after reset", 0,
				{mem_valid_o, dl_ready_o, erasing_o, freeze_o, chrgen_wr_o, ext_rom_o});

		// B6x0 ROM with its last 0x100 bytes past the window
		chr_window = 1'b1;
		send_rom(loader_pkg::IDX_B6X0, 'hB100);
		chr_window = 1'b0;
		assert (wr_count == 'hB000) else value_error("write count", 'hB000, wr_count);
		assert (mem.num() == 'hB000) else value_error("written addresses", 'hB000, mem.num());
		assert (chr_count == 'h1000) else value_error("chrgen_wr_o pulses", 'h1000, chr_count);
		for (int n = 0; n < 'hB000; n++)
			check_mem(cbm2_map_pkg::ROM_B6X0_BASE + n, rom_img[n]);
		assert (ext_rom_o == 3'b000) else value_error("ext_rom_o", 3'b000, ext_rom_o);

		// External ROM at 0x4000
		clear_mem();
		send_rom(loader_pkg::IDX_EXT4000, 'h2000);
		assert (mem.num() == 'h2000) else value_error("written addresses", 'h2000, mem.num());
		for (int n = 0; n < 'h2000; n++)
			check_mem(cbm2_map_pkg::EXT_ROM_BASE1 + n, rom_img[n]);
		assert (ext_rom_o == 3'b010) else value_error("ext_rom_o", 3'b010, ext_rom_o);

		// PRG with header 0x0401 and five data bytes on a B model
		clear_mem();
		model_i     = loader_pkg::MODEL_B;
		dl_index_i  = loader_pkg::IDX_PRG;
		dl_active_i = 1'b1;
		send_byte(25'd0, 8'h01);
		send_byte(25'd1, 8'h04);
		for (int n = 0; n < 5; n++) begin
			send_byte(loader_pkg::mem_addr_t'(n + 2), rom_img[n]);
			assert (freeze_o) else value_error("freeze_o", 1, freeze_o);
		end
		dl_active_i = 1'b0;
		do
			@(posedge clk_sys);
		while (freeze_o);
		wait_mem_idle();
		assert (!freeze_o) else value_error("freeze_o", 0, freeze_o);
		assert (mem.num() == 15) else value_error("written addresses", 15, mem.num());
		for (int n = 0; n < 5; n++)
			check_mem(25'h01_0401 + n, rom_img[n]);
		check_mem(25'h0F_002D, 8'h01);
		check_mem(25'h0F_002E, 8'h04);
		check_mem(25'h0F_002F, 8'h06);
		check_mem(25'h0F_0030, 8'h04);
		check_mem(25'h0F_0096, 8'h06);
		check_mem(25'h0F_0097, 8'h04);
		check_mem(25'h0F_0098, 8'h01);
		check_mem(25'h0F_0099, 8'h01);
		check_mem(25'h0F_009A, 8'h04);
		check_mem(25'h0F_009B, 8'h01);

		// Segment 15 erase with a download waiting for the port
		clear_mem();
		dl_index_i  = loader_pkg::IDX_B7X0;
		dl_offset_i = 25'h10;
		dl_active_i = 1'b1;
		start_erase(loader_pkg::ERASE_SEG15);
		do
			@(posedge clk_sys);
		while (erasing_o);
		#1;
		dl_active_i = 1'b0;
		wait_mem_idle();
		assert (!erasing_o) else value_error("erasing_o", 0, erasing_o);
		assert (wr_count == 'h1800) else value_error("write count", 'h1800, wr_count);
		assert (mem.num() == 'h1800) else value_error("written addresses", 'h1800, mem.num());
		for (int a = 'h0F_0000; a <= 'h0F_0FFF; a++)
			check_mem(a, fill_byte(a));
		for (int a = 'h0F_D000; a <= 'h0F_D7FF; a++)
			check_mem(a, fill_byte(a));

		// Full erase on a 128K P model cancelled midway
		clear_mem();
		model_i = loader_pkg::MODEL_P;
		start_erase(loader_pkg::ERASE_ALL);
		while (wr_count < 1000) begin
			@(posedge clk_sys);
			#1;
		end
		erase_cancel_i = 1'b1;
		@(posedge clk_sys);
		#1;
		erase_cancel_i = 1'b0;
		cancel_count   = wr_count;
		assert (!erasing_o) else value_error("erasing_o", 0, erasing_o);
		repeat (20) @(posedge clk_sys);
		#1;
		assert (wr_count - cancel_count <= 1)
			else plain_error("memory writes went on after the erase was cancelled");
		assert (!mem_valid_o) else value_error("mem_valid_o", 0, mem_valid_o);
		for (int a = 0; a < 1000; a++)
			check_mem(a, fill_byte(a));

		assert (ext_rom_o == 3'b010) else value_error("ext_rom_o", 3'b010, ext_rom_o);
		$display("All tests passed!");
		$finish;
	end

endmodule
